//--- rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam int XLEN       = 32;
    localparam int IMEM_WORDS = 64;
    localparam int DMEM_WORDS = 64;

    // Word index widths
    localparam int IMEM_AW = $clog2(IMEM_WORDS);
    localparam int DMEM_AW = $clog2(DMEM_WORDS);

    localparam logic [XLEN-1:0] RESET_PC = '0;
    localparam logic [XLEN-1:0] PC_MASK  = XLEN'(IMEM_WORDS * 4 - 1); // pc wraps at ROM end

    // Major opcodes handled by the core
    typedef enum logic [6:0] {
        OP_R     = 7'b0110011,
        OP_IMM   = 7'b0010011,
        OP_LOAD  = 7'b0000011,
        OP_STORE = 7'b0100011
    } opcode_e;

    // funct3 codes
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_WORD    = 3'b010; // lw / sw

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

endpackage

`default_nettype wire

//--- inst_mem.sv
`default_nettype none

module inst_mem import rv_pkg::*; (
    input  logic [XLEN-1:0] addr,
    output logic [XLEN-1:0] inst
);

    logic [XLEN-1:0] rom [IMEM_WORDS];

    // Words past the end of the hex file read as zero
    initial begin
        for (int i = 0; i < IMEM_WORDS; i++) begin
            rom[i] = '0;
        end
        $readmemh("prog.hex", rom);
    end

    assign inst = rom[addr[IMEM_AW+1:2]]; // Byte address to word index

    // The pc never carries low bits, fetch is word-only
    always_comb begin
        assert (addr[1:0] == 2'b00)
            else $error("inst_mem: unaligned fetch address %h", addr);
    end

endmodule

`default_nettype wire

//--- register_file.sv
`default_nettype none

module register_file import rv_pkg::*; (
    input  logic            CLK,
    input  logic            RST,
    input  logic [4:0]      rs1,
    input  logic [4:0]      rs2,
    input  logic [4:0]      rd,
    input  logic [XLEN-1:0] wd,
    input  logic            we,
    output logic [XLEN-1:0] rd1,
    output logic [XLEN-1:0] rd2
);

    logic [XLEN-1:0] regs [32];

    always_ff @(posedge CLK) begin
        if (RST) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != 5'd0) begin // x0 is never written
            regs[rd] <= wd;
        end
    end

    // Asynchronous reads
    assign rd1 = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rd2 = (rs2 == 5'd0) ? '0 : regs[rs2];

    // x0 storage must survive any write stream once out of reset
    assert property (@(posedge CLK) disable iff (RST) regs[0] == '0)
        else $error("register_file: x0 changed to %h", regs[0]);

endmodule

`default_nettype wire

//--- data_mem.sv
`default_nettype none

module data_mem import rv_pkg::*; (
    input  logic            CLK,
    input  logic            RST,
    input  logic [XLEN-1:0] addr,
    input  logic [XLEN-1:0] wd,
    input  logic            we,
    output logic [XLEN-1:0] rd
);

    logic [XLEN-1:0]    mem [DMEM_WORDS];
    logic [DMEM_AW-1:0] idx;

    assign idx = addr[DMEM_AW+1:2]; // Upper address bits wrap

    always_ff @(posedge CLK) begin
        if (RST) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[idx] <= wd;
        end
    end

    assign rd = mem[idx]; // Asynchronous read

    // Only word stores are supported
    assert property (@(posedge CLK) disable iff (RST) we |-> addr[1:0] == 2'b00)
        else $error("data_mem: unaligned store to %h", addr);

endmodule

`default_nettype wire

//--- imm_gen.sv
`default_nettype none

module imm_gen import rv_pkg::*; (
    input  logic [XLEN-1:0] inst,
    output logic [XLEN-1:0] imm
);

    opcode_e opcode;

    assign opcode = opcode_e'(inst[6:0]);

    always_comb begin
        case (opcode)
            OP_IMM,
            OP_LOAD: begin
                imm = {{(XLEN-12){inst[31]}}, inst[31:20]}; // I-type
            end
            OP_STORE: begin
                // S-type, split field
                imm = {{(XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- alu.sv
`default_nettype none

module alu import rv_pkg::*; (
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    input  alu_op_e         op,
    output logic [XLEN-1:0] result
);

    logic [4:0] shamt;

    assign shamt = b[4:0]; // Upper bits of b ignored for shifts

    always_comb begin
        case (op)
            ALU_ADD: begin
                result = a + b;
            end
            ALU_SUB: begin
                result = a - b;
            end
            ALU_SLL: begin
                result = a << shamt;
            end
            ALU_SLT: begin
                result = XLEN'($signed(a) < $signed(b));
            end
            ALU_SLTU: begin
                result = XLEN'(a < b);
            end
            ALU_XOR: begin
                result = a ^ b;
            end
            ALU_SRL: begin
                result = a >> shamt;
            end
            ALU_SRA: begin
                result = $signed(a) >>> shamt; // Sign bit fills from the left
            end
            ALU_OR: begin
                result = a | b;
            end
            ALU_AND: begin
                result = a & b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- decoder.sv
`default_nettype none

module decoder import rv_pkg::*; (
    input  logic [XLEN-1:0] inst,
    output logic [4:0]      rs1,
    output logic [4:0]      rs2,
    output logic [4:0]      rd,
    output alu_op_e         alu_op,
    output logic            use_imm,
    output logic            reg_we,
    output logic            mem_we,
    output logic            mem_to_reg
);

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       alt;       // inst[30], sub / sra
    logic       funct7_ok; // funct7 zero apart from bit 30
    logic       r_ok;
    logic       imm_ok;

    function automatic alu_op_e f3_to_op(input logic [2:0] f3, input logic sel_alt);
        case (f3)
            F3_ADD_SUB: return sel_alt ? ALU_SUB : ALU_ADD;
            F3_SLL:     return ALU_SLL;
            F3_SLT:     return ALU_SLT;
            F3_SLTU:    return ALU_SLTU;
            F3_XOR:     return ALU_XOR;
            F3_SRL_SRA: return sel_alt ? ALU_SRA : ALU_SRL;
            F3_OR:      return ALU_OR;
            default:    return ALU_AND;
        endcase
    endfunction

    assign opcode = opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign alt    = inst[30];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign rd     = inst[11:7];

    assign funct7_ok = (funct7 & 7'b1011111) == 7'b0000000;
    // Bit 30 only legal on add/sub and srl/sra
    assign r_ok = funct7_ok && (!alt || funct3 == F3_ADD_SUB || funct3 == F3_SRL_SRA);
    // Immediate shifts carry funct7 in the immediate field
    assign imm_ok = (funct3 == F3_SLL)     ? funct7 == 7'b0000000 :
                    (funct3 == F3_SRL_SRA) ? funct7_ok : 1'b1;

    always_comb begin
        alu_op     = ALU_ADD; // Address add for lw / sw
        use_imm    = 1'b0;
        reg_we     = 1'b0;
        mem_we     = 1'b0;
        mem_to_reg = 1'b0;
        case (opcode)
            OP_R: begin
                if (r_ok) begin
                    alu_op = f3_to_op(funct3, alt);
                    reg_we = 1'b1;
                end
            end
            OP_IMM: begin
                if (imm_ok) begin
                    alu_op  = f3_to_op(funct3, funct3 == F3_SRL_SRA && alt);
                    use_imm = 1'b1;
                    reg_we  = 1'b1;
                end
            end
            OP_LOAD: begin
                if (funct3 == F3_WORD) begin
                    use_imm    = 1'b1;
                    reg_we     = 1'b1;
                    mem_to_reg = 1'b1;
                end
            end
            OP_STORE: begin
                if (funct3 == F3_WORD) begin
                    use_imm = 1'b1;
                    mem_we  = 1'b1;
                end
            end
            default: ; // Retires as a no-op
        endcase
    end

    always_comb begin
        assert (!(reg_we && mem_we))
            else $error("decoder: register and memory write both set for %h", inst);
    end

endmodule

`default_nettype wire

//--- single_cpu.sv
`default_nettype none

module single_cpu import rv_pkg::*; (
    input  logic            CLK,
    input  logic            RST,
    output logic [XLEN-1:0] pc,
    output logic [XLEN-1:0] inst,
    output logic            wb_en,
    output logic [4:0]      wb_addr,
    output logic [XLEN-1:0] wb_data
);

    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [4:0]      rd;
    alu_op_e         alu_op;
    logic            use_imm;
    logic            reg_we;
    logic            mem_we;
    logic            mem_to_reg;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] rd1;
    logic [XLEN-1:0] rd2;
    logic [XLEN-1:0] alu_b;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] mem_rdata;

    always_ff @(posedge CLK) begin
        if (RST) begin
            pc <= RESET_PC;
        end else begin
            pc <= (pc + XLEN'(4)) & PC_MASK; // Wraps after last ROM word
        end
    end

    inst_mem u_inst_mem (.addr(pc), .inst(inst));

    decoder u_decoder (
        .inst(inst), .rs1(rs1), .rs2(rs2), .rd(rd), .alu_op(alu_op),
        .use_imm(use_imm), .reg_we(reg_we), .mem_we(mem_we), .mem_to_reg(mem_to_reg)
    );

    imm_gen u_imm_gen (.inst(inst), .imm(imm));

    register_file u_register_file (
        .CLK(CLK), .RST(RST), .rs1(rs1), .rs2(rs2), .rd(rd),
        .wd(wb_data), .we(reg_we), .rd1(rd1), .rd2(rd2)
    );

    assign alu_b = use_imm ? imm : rd2; // Operand select

    alu u_alu (.a(rd1), .b(alu_b), .op(alu_op), .result(alu_result));

    data_mem u_data_mem (
        .CLK(CLK), .RST(RST), .addr(alu_result), .wd(rd2), .we(mem_we), .rd(mem_rdata)
    );

    // Write-back
    assign wb_data = mem_to_reg ? mem_rdata : alu_result;
    assign wb_addr = rd;
    assign wb_en   = reg_we && rd != 5'd0; // Writes to x0 are not reported

endmodule

`default_nettype wire

//--- tb_clock.sv
`default_nettype none

module tb_clock #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 8
) (
    output logic CLK,
    output logic RST
);

    initial begin
        CLK = 1'b0;
        forever begin
            #(PERIOD / 2) CLK = ~CLK;
        end
    end

    // Reset released shortly after its last edge
    initial begin
        RST = 1'b1;
        repeat (RESET_CYCLES) @(posedge CLK);
        #1;
        RST = 1'b0;
    end

endmodule

`default_nettype wire

//--- tb_single_cpu.sv
`default_nettype none

module tb_single_cpu import rv_pkg::*; ();

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 8;
    localparam int PASSES       = 2;                     // Full trips through the ROM
    localparam int NUM_CYCLES   = PASSES * IMEM_WORDS;
    localparam int TIMEOUT      = (RESET_CYCLES + NUM_CYCLES + 10) * CLK_PERIOD;

    logic            CLK;
    logic            RST;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] inst;
    logic            wb_en;
    logic [4:0]      wb_addr;
    logic [XLEN-1:0] wb_data;

    // Architectural model state
    logic [XLEN-1:0] model_rom  [IMEM_WORDS];
    logic [XLEN-1:0] model_regs [32];
    logic [XLEN-1:0] model_mem  [DMEM_WORDS];
    int              model_index;                        // Word index of the next instruction

    int error_count;
    int check_count;

    tb_clock #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) u_clock (
        .CLK(CLK),
        .RST(RST)
    );

    single_cpu dut (
        .CLK(CLK), .RST(RST), .pc(pc), .inst(inst),
        .wb_en(wb_en), .wb_addr(wb_addr), .wb_data(wb_data)
    );

    // RV32I integer result for a funct3 and the bit 30 modifier
    function automatic logic [XLEN-1:0] integer_op(
        input logic [2:0]      f3,
        input logic            alt,
        input logic [XLEN-1:0] a,
        input logic [XLEN-1:0] b
    );
        logic [4:0]             sh;
        logic signed [XLEN-1:0] arith;
        logic [XLEN-1:0]        res;

        sh    = b[4:0];
        arith = $signed(a) >>> sh;
        case (f3)
            F3_ADD_SUB: res = alt ? a - b : a + b;
            F3_SLL:     res = a << sh;
            F3_SLT:     res = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            F3_SLTU:    res = {{(XLEN-1){1'b0}}, a < b};
            F3_XOR:     res = a ^ b;
            F3_SRL_SRA: res = alt ? arith : a >> sh;
            F3_OR:      res = a | b;
            default:    res = a & b;
        endcase
        return res;
    endfunction

    // Retires one instruction on the model and gives the trace it should produce
    function automatic void execute_model(
        output logic [XLEN-1:0] exp_pc,
        output logic [XLEN-1:0] exp_inst,
        output logic            exp_wb_en,
        output logic [4:0]      exp_wb_addr,
        output logic [XLEN-1:0] exp_wb_data
    );
        logic [XLEN-1:0] word;
        logic [6:0]      opcode;
        logic [2:0]      funct3;
        logic [6:0]      funct7;
        logic [4:0]      rd;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] imm_i;
        logic [XLEN-1:0] imm_s;
        logic [XLEN-1:0] addr;
        logic            writes;
        logic            legal;
        logic [XLEN-1:0] value;
        int              mem_index;

        word   = model_rom[model_index];
        opcode = word[6:0];
        funct3 = word[14:12];
        funct7 = word[31:25];
        rd     = word[11:7];
        a      = model_regs[word[19:15]];
        b      = model_regs[word[24:20]];
        imm_i  = {{(XLEN-12){word[31]}}, word[31:20]};
        imm_s  = {{(XLEN-12){word[31]}}, word[31:25], word[11:7]};
        writes = 1'b0;
        value  = '0;

        case (opcode)
            OP_R: begin
                // funct7 of 0x20 only exists for sub and sra
                legal = funct7 == 7'h00 ||
                        (funct7 == 7'h20 && (funct3 == F3_ADD_SUB || funct3 == F3_SRL_SRA));
                if (legal) begin
                    value  = integer_op(funct3, funct7[5], a, b);
                    writes = 1'b1;
                end
            end
            OP_IMM: begin
                if (funct3 == F3_SLL) begin
                    legal = funct7 == 7'h00;
                end else if (funct3 == F3_SRL_SRA) begin
                    legal = funct7 == 7'h00 || funct7 == 7'h20;
                end else begin
                    legal = 1'b1;
                end
                if (legal) begin
                    value  = integer_op(funct3, funct3 == F3_SRL_SRA && word[30], a, imm_i);
                    writes = 1'b1;
                end
            end
            OP_LOAD: begin
                if (funct3 == F3_WORD) begin
                    addr      = a + imm_i;
                    mem_index = int'((addr >> 2) % XLEN'(DMEM_WORDS));
                    value     = model_mem[mem_index];
                    writes    = 1'b1;
                end
            end
            OP_STORE: begin
                if (funct3 == F3_WORD) begin
                    addr      = a + imm_s;
                    mem_index = int'((addr >> 2) % XLEN'(DMEM_WORDS));
                    model_mem[mem_index] = b;
                end
            end
            default: ; // Unsupported, no state change
        endcase

        exp_pc      = XLEN'(model_index * 4);
        exp_inst    = word;
        exp_wb_en   = writes && rd != 5'd0;
        exp_wb_addr = rd;
        exp_wb_data = value;
        if (exp_wb_en) begin
            model_regs[rd] = value;
        end
        model_index = (model_index + 1) % IMEM_WORDS; // pc wraps at the ROM end
    endfunction

    task automatic check_value(
        input string           name,
        input logic [XLEN-1:0] actual,
        input logic [XLEN-1:0] expected
    );
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Error: %s is %h, expected %h at time %0t", name, actual, expected, $time);
        end
    endtask

    initial begin : compare
        logic [XLEN-1:0] exp_pc;
        logic [XLEN-1:0] exp_inst;
        logic            exp_wb_en;
        logic [4:0]      exp_wb_addr;
        logic [XLEN-1:0] exp_wb_data;

        error_count = 0;
        check_count = 0;
        model_index = 0;
        for (int i = 0; i < IMEM_WORDS; i++) begin
            model_rom[i] = '0;
        end
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            model_mem[i] = '0;
        end
        $readmemh("prog.hex", model_rom);

        @(negedge RST);
        for (int cycle = 0; cycle < NUM_CYCLES; cycle++) begin
            @(negedge CLK);
            #(CLK_PERIOD / 2 - 1);                       // Just before the retiring edge
            execute_model(exp_pc, exp_inst, exp_wb_en, exp_wb_addr, exp_wb_data);
            check_value("pc", pc, exp_pc);
            check_value("inst", inst, exp_inst);
            check_value("wb_en", XLEN'(wb_en), XLEN'(exp_wb_en));
            if (exp_wb_en) begin
                check_value("wb_addr", XLEN'(wb_addr), XLEN'(exp_wb_addr));
                check_value("wb_data", wb_data, exp_wb_data);
            end
        end

        $display("Checks run: %0d, mismatches: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin : watchdog
        #(TIMEOUT);
        $display("Timeout: the run did not finish within %0d time units", TIMEOUT);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

//--- prog.hex
// Instruction ROM image for the single-cycle core
// One 32-bit instruction word in hex per line, from word 0 upward
FF900093 // addi x1, x0, -7
00300113 // addi x2, x0, 3
002081B3 // add  x3, x1, x2
40208233 // sub  x4, x1, x2
002092B3 // sll  x5, x1, x2
0020A333 // slt  x6, x1, x2
0020B3B3 // sltu x7, x1, x2
0020C433 // xor  x8, x1, x2
0020D4B3 // srl  x9, x1, x2
4020D533 // sra  x10, x1, x2
0020E5B3 // or   x11, x1, x2
0020F633 // and  x12, x1, x2
FFF0A693 // slti  x13, x1, -1
FFF13713 // sltiu x14, x2, -1
FFF0C793 // xori  x15, x1, -1
0F016813 // ori   x16, x2, 0x0f0
0FF0F893 // andi  x17, x1, 0x0ff
00409913 // slli  x18, x1, 4
0040D993 // srli  x19, x1, 4
4040DA13 // srai  x20, x1, 4
00402823 // sw x4, 16(x0)
01002A83 // lw x21, 16(x0)
06402B03 // lw x22, 100(x0), never written
00500013 // addi x0, x0, 5
00000BB3 // add x23, x0, x0
00208463 // beq x1, x2, 8, unsupported
FE202E23 // sw x2, -4(x0)
FFC02C03 // lw x24, -4(x0)
015C0CB3 // add x25, x24, x21
40125D13 // srai x26, x4, 1
40110DB3 // sub x27, x2, x1
123450B7 // lui x1, 0x12345, unsupported

//--- verilog.f
rv_pkg.sv
inst_mem.sv
register_file.sv
data_mem.sv
imm_gen.sv
alu.sv
decoder.sv
single_cpu.sv
tb_clock.sv
tb_single_cpu.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only -Wall --timing
TOP       := tb_single_cpu
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := No errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
